// File: disp_top.f
logic/disp_pkg.sv
logic/disp_timing.sv
logic/test_pattern.sv
logic/channel_scale.sv
logic/disp_output.sv
logic/disp_top.sv
verification/disp_top_chk.sv
verification/disp_top_tb.sv

// File: logic/channel_scale.sv
`timescale 1ns/1ps

module channel_scale import disp_pkg::*; (
    input  logic  disp_clk,
    input  logic  reset,
    input  logic  en,
    input  logic  valid_in,
    input  chan_t chan_in,
    input  gain_t gain,
    input  chan_t offset,
    output chan_t chan_out,
    output logic  valid_out
);

    logic [CHAN_W+GAIN_W-1:0] product;
    logic [CHAN_W:0]          scaled;          // Up to 508 at maximum gain
    logic [CHAN_W+1:0]        sum;

    assign product = chan_in * gain;
    assign scaled  = product[CHAN_W+GAIN_W-1:GAIN_FRAC];
    assign sum     = {1'b0, scaled} + {2'b00, offset};

    always_ff @(posedge disp_clk) begin
        if (reset || !en) begin
            chan_out  <= '0;
            valid_out <= 1'b0;
        end else begin
            // Clip to full scale
            chan_out  <= (sum > CHAN_MAX) ? CHAN_MAX : sum[CHAN_W-1:0];
            valid_out <= valid_in;
        end
    end

endmodule

// File: logic/disp_output.sv
`timescale 1ns/1ps

module disp_output import disp_pkg::*; (
    input  logic  disp_clk,
    input  logic  reset,
    input  logic  en,
    input  logic  hsync,
    input  logic  vsync,
    input  logic  pix_valid,
    input  chan_t red_in,
    input  chan_t green_in,
    input  chan_t blue_in,
    output logic  disp_hsync,
    output logic  disp_vsync,
    output logic  disp_de,
    output chan_t red_out,
    output chan_t green_out,
    output chan_t blue_out
);

    // Sync delay lines match the pattern and scale stages
    logic [PIPE_DEPTH-1:0] hsync_dly;
    logic [PIPE_DEPTH-1:0] vsync_dly;

    always_ff @(posedge disp_clk) begin
        if (reset || !en) begin
            hsync_dly  <= '0;
            vsync_dly  <= '0;
            disp_hsync <= 1'b0;
            disp_vsync <= 1'b0;
            disp_de    <= 1'b0;
            red_out    <= '0;
            green_out  <= '0;
            blue_out   <= '0;
        end else begin
            hsync_dly  <= {hsync_dly[PIPE_DEPTH-2:0], hsync};
            vsync_dly  <= {vsync_dly[PIPE_DEPTH-2:0], vsync};
            disp_hsync <= hsync_dly[PIPE_DEPTH-1];
            disp_vsync <= vsync_dly[PIPE_DEPTH-1];
            disp_de    <= pix_valid;
            red_out    <= pix_valid ? red_in : '0;     // Blank outside active area
            green_out  <= pix_valid ? green_in : '0;
            blue_out   <= pix_valid ? blue_in : '0;
        end
    end

endmodule

// File: logic/disp_pkg.sv
package disp_pkg;

    // Coordinate and counter width
    localparam int POS_W = 10;

    // Colour channel and gain widths
    localparam int CHAN_W = 8;
    localparam int GAIN_W = 8;
    localparam int GAIN_FRAC = 7;              // 128 is unity gain

    localparam int NUM_CHAN = 3;               // Red, green, blue

    // Pixel-path register stages between disp_timing and disp_output
    localparam int PIPE_DEPTH = 2;

    typedef logic [POS_W-1:0]  pos_t;
    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [GAIN_W-1:0] gain_t;

    localparam chan_t CHAN_MAX = '1;           // Full-scale channel value

    typedef enum logic [1:0] {
        PAT_BARS     = 2'd0,
        PAT_CHECKER  = 2'd1,
        PAT_GRADIENT = 2'd2,
        PAT_WHITE    = 2'd3
    } pattern_e;

endpackage

// File: logic/disp_timing.sv
`timescale 1ns/1ps

module disp_timing import disp_pkg::*; #(
    parameter int HORZ_PIXELS      = 480,
    parameter int VERT_PIXELS      = 272,
    parameter int HORZ_LOW_WIDTH   = 41,
    parameter int HORZ_FRONT_PORCH = 2,
    parameter int HORZ_BACK_PORCH  = 2,
    parameter int VERT_LOW_WIDTH   = 10,
    parameter int VERT_FRONT_PORCH = 2,
    parameter int VERT_BACK_PORCH  = 2
) (
    input  logic disp_clk,
    input  logic reset,
    input  logic en,
    output logic hsync,
    output logic vsync,
    output logic valid_draw,
    output logic frame_start,
    output pos_t h_pos,
    output pos_t v_pos
);

    localparam int H_TOTAL = HORZ_LOW_WIDTH + HORZ_FRONT_PORCH + HORZ_PIXELS + HORZ_BACK_PORCH;
    localparam int V_TOTAL = VERT_LOW_WIDTH + VERT_FRONT_PORCH + VERT_PIXELS + VERT_BACK_PORCH;

    localparam pos_t H_SYNC_END = pos_t'(HORZ_LOW_WIDTH);
    localparam pos_t H_START    = pos_t'(HORZ_LOW_WIDTH + HORZ_FRONT_PORCH);
    localparam pos_t H_END      = pos_t'(HORZ_LOW_WIDTH + HORZ_FRONT_PORCH + HORZ_PIXELS);
    localparam pos_t H_LAST     = pos_t'(H_TOTAL - 1);

    localparam pos_t V_SYNC_END = pos_t'(VERT_LOW_WIDTH);
    localparam pos_t V_START    = pos_t'(VERT_LOW_WIDTH + VERT_FRONT_PORCH);
    localparam pos_t V_END      = pos_t'(VERT_LOW_WIDTH + VERT_FRONT_PORCH + VERT_PIXELS);
    localparam pos_t V_LAST     = pos_t'(V_TOTAL - 1);

    pos_t h_count;
    pos_t v_count;
    pos_t h_next;
    pos_t v_next;
    logic running;                             // Low on the first enabled cycle
    logic h_wrap;

    // Next count; the first enabled cycle holds count zero
    always_comb begin
        h_wrap = (h_count == H_LAST);
        if (!running) begin
            h_next = '0;
            v_next = '0;
        end else begin
            h_next = h_wrap ? '0 : h_count + pos_t'(1);
            if (h_wrap) begin
                v_next = (v_count == V_LAST) ? '0 : v_count + pos_t'(1);  // New line
            end else begin
                v_next = v_count;
            end
        end
    end

    // Outputs describe the count that is registered in the same cycle
    always_ff @(posedge disp_clk) begin
        if (reset || !en) begin
            running     <= 1'b0;
            h_count     <= '0;
            v_count     <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            valid_draw  <= 1'b0;
            frame_start <= 1'b0;
            h_pos       <= '0;
            v_pos       <= '0;
        end else begin
            running     <= 1'b1;
            h_count     <= h_next;
            v_count     <= v_next;
            hsync       <= (h_next >= H_SYNC_END);     // Low pulse at line start
            vsync       <= (v_next >= V_SYNC_END);     // Low pulse at frame start
            valid_draw  <= (h_next >= H_START) && (h_next < H_END) &&
                           (v_next >= V_START) && (v_next < V_END);
            frame_start <= (h_next == '0) && (v_next == '0);
            h_pos       <= h_next - H_START;
            v_pos       <= v_next - V_START;
        end
    end

endmodule

// File: logic/disp_top.sv
`timescale 1ns/1ps

module disp_top import disp_pkg::*; #(
    parameter int HORZ_PIXELS      = 480,
    parameter int VERT_PIXELS      = 272,
    parameter int HORZ_LOW_WIDTH   = 41,
    parameter int HORZ_FRONT_PORCH = 2,
    parameter int HORZ_BACK_PORCH  = 2,
    parameter int VERT_LOW_WIDTH   = 10,
    parameter int VERT_FRONT_PORCH = 2,
    parameter int VERT_BACK_PORCH  = 2
) (
    input  logic     disp_clk,
    input  logic     reset,
    input  logic     en,
    input  pattern_e pattern,
    input  gain_t    gain_red,
    input  gain_t    gain_green,
    input  gain_t    gain_blue,
    input  chan_t    offset_red,
    input  chan_t    offset_green,
    input  chan_t    offset_blue,
    output logic     disp_hsync,
    output logic     disp_vsync,
    output logic     disp_de,
    output chan_t    red_out,
    output chan_t    green_out,
    output chan_t    blue_out
);

    logic hsync;
    logic vsync;
    logic valid_draw;
    logic frame_start;
    pos_t h_pos;
    pos_t v_pos;
    logic pat_valid;

    // Channel index 0 is red, 1 green, 2 blue
    chan_t [NUM_CHAN-1:0] pat_chan;
    chan_t [NUM_CHAN-1:0] scaled_chan;
    gain_t [NUM_CHAN-1:0] chan_gain;
    chan_t [NUM_CHAN-1:0] chan_offset;
    logic  [NUM_CHAN-1:0] scaled_valid;

    assign chan_gain   = {gain_blue, gain_green, gain_red};
    assign chan_offset = {offset_blue, offset_green, offset_red};

    disp_timing #(
        .HORZ_PIXELS      (HORZ_PIXELS),
        .VERT_PIXELS      (VERT_PIXELS),
        .HORZ_LOW_WIDTH   (HORZ_LOW_WIDTH),
        .HORZ_FRONT_PORCH (HORZ_FRONT_PORCH),
        .HORZ_BACK_PORCH  (HORZ_BACK_PORCH),
        .VERT_LOW_WIDTH   (VERT_LOW_WIDTH),
        .VERT_FRONT_PORCH (VERT_FRONT_PORCH),
        .VERT_BACK_PORCH  (VERT_BACK_PORCH)
    ) u_disp_timing (
        .disp_clk    (disp_clk),
        .reset       (reset),
        .en          (en),
        .hsync       (hsync),
        .vsync       (vsync),
        .valid_draw  (valid_draw),
        .frame_start (frame_start),
        .h_pos       (h_pos),
        .v_pos       (v_pos)
    );

    test_pattern #(
        .HORZ_PIXELS (HORZ_PIXELS)
    ) u_test_pattern (
        .disp_clk    (disp_clk),
        .reset       (reset),
        .en          (en),
        .valid_draw  (valid_draw),
        .frame_start (frame_start),
        .pattern     (pattern),
        .h_pos       (h_pos),
        .v_pos       (v_pos),
        .red         (pat_chan[0]),
        .green       (pat_chan[1]),
        .blue        (pat_chan[2]),
        .pix_valid   (pat_valid)
    );

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        channel_scale u_channel_scale (
            .disp_clk  (disp_clk),
            .reset     (reset),
            .en        (en),
            .valid_in  (pat_valid),
            .chan_in   (pat_chan[i]),
            .gain      (chan_gain[i]),
            .offset    (chan_offset[i]),
            .chan_out  (scaled_chan[i]),
            .valid_out (scaled_valid[i])
        );
    end

    disp_output u_disp_output (
        .disp_clk   (disp_clk),
        .reset      (reset),
        .en         (en),
        .hsync      (hsync),
        .vsync      (vsync),
        .pix_valid  (&scaled_valid),               // All channels move in lockstep
        .red_in     (scaled_chan[0]),
        .green_in   (scaled_chan[1]),
        .blue_in    (scaled_chan[2]),
        .disp_hsync (disp_hsync),
        .disp_vsync (disp_vsync),
        .disp_de    (disp_de),
        .red_out    (red_out),
        .green_out  (green_out),
        .blue_out   (blue_out)
    );

endmodule

// File: logic/test_pattern.sv
`timescale 1ns/1ps

module test_pattern import disp_pkg::*; #(
    parameter int HORZ_PIXELS = 480
) (
    input  logic     disp_clk,
    input  logic     reset,
    input  logic     en,
    input  logic     valid_draw,
    input  logic     frame_start,
    input  pattern_e pattern,
    input  pos_t     h_pos,
    input  pos_t     v_pos,
    output chan_t    red,
    output chan_t    green,
    output chan_t    blue,
    output logic     pix_valid
);

    localparam pos_t BAR_WIDTH = pos_t'(HORZ_PIXELS / 8);

    pattern_e pattern_q;                       // Held for the whole frame
    pos_t     bar_div;
    logic [2:0] bar_idx;
    chan_t    pat_r;
    chan_t    pat_g;
    chan_t    pat_b;

    assign bar_div = h_pos / BAR_WIDTH;
    assign bar_idx = bar_div[2:0];

    always_comb begin
        pat_r = '0;
        pat_g = '0;
        pat_b = '0;
        case (pattern_q)
            PAT_BARS: begin
                pat_r = bar_idx[2] ? CHAN_MAX : '0;
                pat_g = bar_idx[1] ? CHAN_MAX : '0;
                pat_b = bar_idx[0] ? CHAN_MAX : '0;
            end
            PAT_CHECKER: begin
                // 16 pixel squares
                pat_r = (h_pos[4] ^ v_pos[4]) ? CHAN_MAX : '0;
                pat_g = pat_r;
                pat_b = pat_r;
            end
            PAT_GRADIENT: begin
                pat_r = h_pos[CHAN_W-1:0];
                pat_g = v_pos[CHAN_W-1:0];
                pat_b = CHAN_MAX - h_pos[CHAN_W-1:0];
            end
            PAT_WHITE: begin
                pat_r = CHAN_MAX;
                pat_g = CHAN_MAX;
                pat_b = CHAN_MAX;
            end
        endcase
    end

    always_ff @(posedge disp_clk) begin
        if (reset) begin
            pattern_q <= PAT_BARS;
        end else if (frame_start) begin
            pattern_q <= pattern;              // Change only at frame boundary
        end
    end

    always_ff @(posedge disp_clk) begin
        if (reset || !en) begin
            red       <= '0;
            green     <= '0;
            blue      <= '0;
            pix_valid <= 1'b0;
        end else begin
            red       <= valid_draw ? pat_r : '0;
            green     <= valid_draw ? pat_g : '0;
            blue      <= valid_draw ? pat_b : '0;
            pix_valid <= valid_draw;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module disp_top_tb -f disp_top.f -o disp_top_sim \
    && ./obj_dir/disp_top_sim > "$LOG" 2>&1 \
    || echo "Build or simulation stopped with an error"

[ -f "$LOG" ] && cat "$LOG"

grep -qx "Regression passed" "$LOG" \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }

// File: verification/disp_top_chk.sv
`timescale 1ns/1ps

module disp_top_chk import disp_pkg::*; (
    input logic  disp_clk,
    input logic  reset,
    input logic  en,
    input logic  disp_hsync,
    input logic  disp_vsync,
    input logic  disp_de,
    input chan_t red_out,
    input chan_t green_out,
    input chan_t blue_out
);

    logic colour_zero;

    assign colour_zero = (red_out == '0) && (green_out == '0) && (blue_out == '0);

    // Active pixels only inside both sync high windows
    a_de_in_sync: assert property (@(posedge disp_clk) disable iff (reset)
        disp_de |-> (disp_hsync && disp_vsync))
        else $error("disp_de high while a sync pin is low");

    a_blank: assert property (@(posedge disp_clk) disable iff (reset)
        !disp_de |-> colour_zero)
        else $error("colour pins nonzero while disp_de is low");

    // Pins clear one edge after reset or en low is sampled
    a_quiet: assert property (@(posedge disp_clk)
        (reset || !en) |=> (!disp_hsync && !disp_vsync && !disp_de && colour_zero))
        else $error("outputs active while disabled");

endmodule

// File: verification/disp_top_tb.sv
`timescale 1ns/1ps

module disp_top_tb import disp_pkg::*; ();

    localparam int H_PIX = 32;
    localparam int V_PIX = 8;
    localparam int H_LOW = 3;
    localparam int V_LOW = 2;
    localparam int PORCH = 2;
    localparam int H_TOTAL = H_LOW + PORCH + H_PIX + PORCH;
    localparam int V_TOTAL = V_LOW + PORCH + V_PIX + PORCH;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int EN_TO_PIN = 4;              // en seen, count 0 registered, 3 stages
    localparam int NUM_ROWS = 8;

    typedef struct packed {
        logic     en;
        pattern_e pat;
        gain_t    gain_r;
        gain_t    gain_g;
        gain_t    gain_b;
        chan_t    offset_r;
        chan_t    offset_g;
        chan_t    offset_b;
        int       frames;
    } row_t;

    // en, pattern, gains r g b, offsets r g b, frames
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b1, PAT_BARS,     8'd128, 8'd128, 8'd128, 8'd0,   8'd0,   8'd0,  1},
        '{1'b1, PAT_CHECKER,  8'd128, 8'd128, 8'd128, 8'd0,   8'd0,   8'd0,  1},
        '{1'b1, PAT_GRADIENT, 8'd128, 8'd128, 8'd128, 8'd0,   8'd0,   8'd0,  2},
        '{1'b1, PAT_WHITE,    8'd128, 8'd128, 8'd128, 8'd0,   8'd0,   8'd0,  1},
        '{1'b0, PAT_WHITE,    8'd128, 8'd128, 8'd128, 8'd0,   8'd0,   8'd0,  1},
        '{1'b1, PAT_GRADIENT, 8'd64,  8'd128, 8'd255, 8'd10,  8'd20,  8'd30, 1},
        '{1'b1, PAT_WHITE,    8'd255, 8'd64,  8'd128, 8'd0,   8'd200, 8'd5,  1},
        '{1'b1, PAT_BARS,     8'd64,  8'd64,  8'd64,  8'd100, 8'd0,   8'd0,  1}
    };

    logic     disp_clk;
    logic     reset;
    logic     en;
    pattern_e pattern;
    gain_t    gain_red;
    gain_t    gain_green;
    gain_t    gain_blue;
    chan_t    offset_red;
    chan_t    offset_green;
    chan_t    offset_blue;
    logic     disp_hsync;
    logic     disp_vsync;
    logic     disp_de;
    chan_t    red_out;
    chan_t    green_out;
    chan_t    blue_out;
    int       errors;
    int       checks;
    logic     run_ok;

    disp_top #(
        .HORZ_PIXELS (H_PIX), .VERT_PIXELS (V_PIX),
        .HORZ_LOW_WIDTH (H_LOW), .HORZ_FRONT_PORCH (PORCH), .HORZ_BACK_PORCH (PORCH),
        .VERT_LOW_WIDTH (V_LOW), .VERT_FRONT_PORCH (PORCH), .VERT_BACK_PORCH (PORCH)
    ) u_disp_top (.*);

    bind disp_top disp_top_chk u_disp_top_chk (
        .disp_clk (disp_clk), .reset (reset), .en (en),
        .disp_hsync (disp_hsync), .disp_vsync (disp_vsync), .disp_de (disp_de),
        .red_out (red_out), .green_out (green_out), .blue_out (blue_out)
    );

    initial begin
        disp_clk = 1'b0;
        forever #4 disp_clk = ~disp_clk;
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_quiet();
        check_value("disp_hsync", int'(disp_hsync), 0);
        check_value("disp_vsync", int'(disp_vsync), 0);
        check_value("disp_de", int'(disp_de), 0);
        check_value("red_out", int'(red_out), 0);
        check_value("green_out", int'(green_out), 0);
        check_value("blue_out", int'(blue_out), 0);
    endtask

    // Reference colour before scaling, ch 0 is red
    function automatic int pattern_colour(input pattern_e pat, input int x, input int y,
                                          input int ch);
        int bar;
        int c;
        bar = x / (H_PIX / 8);
        case (pat)
            PAT_BARS:     c = ((bar >> (2 - ch)) & 1) ? 255 : 0;
            PAT_CHECKER:  c = (((x >> 4) ^ (y >> 4)) & 1) ? 255 : 0;
            PAT_GRADIENT: c = (ch == 0) ? (x % 256) : (ch == 1) ? (y % 256) : 255 - (x % 256);
            default:      c = 255;
        endcase
        return c;
    endfunction

    function automatic int scaled_colour(input int base, input int gain, input int offset);
        int v;
        v = (base * gain) / 128 + offset;
        return (v > 255) ? 255 : v;
    endfunction

    task automatic wait_vsync_edge(input logic rising, input int expect_n, input string what,
                                   output logic ok);
        int   n;
        logic prev;
        logic seen;
        n = 0;
        prev = disp_vsync;
        seen = 1'b0;
        while (!seen && n < 2 * FRAME_CYCLES) begin
            @(negedge disp_clk);
            n++;
            seen = rising ? (!prev && disp_vsync) : (prev && !disp_vsync);
            prev = disp_vsync;
        end
        ok = seen;
        if (!seen) begin
            errors++;
            $display("Timeout: disp_vsync edge for %s never came", what);
        end else if (expect_n > 0) begin
            check_value(what, n, expect_n);
        end
    endtask

    // Starts on the sample where disp_vsync fell, ends on the next fall
    task automatic check_frame(input row_t row, output logic ok);
        int   cyc;
        int   line;
        int   last_hfall;
        int   x;
        int   y;
        logic prev_h;
        logic prev_v;
        logic done;
        cyc = 0;
        line = 0;
        last_hfall = 0;
        x = 0;
        y = 0;
        prev_h = 1'b0;
        prev_v = 1'b0;
        done = 1'b0;
        while (!done && cyc < 2 * FRAME_CYCLES) begin
            @(negedge disp_clk);
            cyc++;
            if (prev_h && !disp_hsync) begin
                check_value("disp_hsync period", cyc - last_hfall, H_TOTAL);
                if (x != 0) begin
                    check_value("disp_de per line", x, H_PIX);
                    y++;
                end
                x = 0;
                last_hfall = cyc;
                line++;
            end
            if (!prev_h && disp_hsync) check_value("disp_hsync low", cyc - last_hfall, H_LOW);
            if (!prev_v && disp_vsync) check_value("disp_vsync low", cyc, V_LOW * H_TOTAL);
            if (prev_v && !disp_vsync) begin
                check_value("disp_vsync period", cyc, FRAME_CYCLES);
                done = 1'b1;
            end else if (disp_de) begin
                if (x == 0) begin
                    check_value("disp_de start", cyc - last_hfall, H_LOW + PORCH);
                    if (y == 0) check_value("disp_de first line", line, V_LOW + PORCH);
                end
                check_value("red_out", int'(red_out),
                            scaled_colour(pattern_colour(row.pat, x, y, 0), row.gain_r, row.offset_r));
                check_value("green_out", int'(green_out),
                            scaled_colour(pattern_colour(row.pat, x, y, 1), row.gain_g, row.offset_g));
                check_value("blue_out", int'(blue_out),
                            scaled_colour(pattern_colour(row.pat, x, y, 2), row.gain_b, row.offset_b));
                x++;
            end else begin
                check_value("red_out", int'(red_out), 0);      // Blanked outside active area
                check_value("green_out", int'(green_out), 0);
                check_value("blue_out", int'(blue_out), 0);
            end
            prev_h = disp_hsync;
            prev_v = disp_vsync;
        end
        check_value("disp_de lines", y, V_PIX);
        ok = done;
        if (!done) begin
            errors++;
            $display("Timeout: frame did not end with a disp_vsync falling edge");
        end
    endtask

    task automatic run_row(input row_t row, output logic ok);
        int low_cycles;
        ok = 1'b1;
        low_cycles = row.en ? 4 + int'($urandom % 16) : row.frames * FRAME_CYCLES;
        @(posedge disp_clk);
        en           <= 1'b0;
        pattern      <= row.pat;
        gain_red     <= row.gain_r;
        gain_green   <= row.gain_g;
        gain_blue    <= row.gain_b;
        offset_red   <= row.offset_r;
        offset_green <= row.offset_g;
        offset_blue  <= row.offset_b;
        @(posedge disp_clk);                   // DUT clears on this edge
        repeat (low_cycles) begin
            @(negedge disp_clk);
            check_quiet();
        end
        if (row.en) begin
            @(posedge disp_clk);
            en <= 1'b1;
            @(negedge disp_clk);
            wait_vsync_edge(1'b1, EN_TO_PIN + V_LOW * H_TOTAL, "first disp_vsync rise", ok);
            if (ok) wait_vsync_edge(1'b1, FRAME_CYCLES, "disp_vsync rise period", ok);
            if (ok) wait_vsync_edge(1'b0, 0, "frame start", ok);
            for (int f = 0; f < row.frames && ok; f++) begin
                check_frame(row, ok);
            end
        end
    endtask

    initial begin
        void'($urandom(33324));
        errors       = 0;
        checks       = 0;
        run_ok       = 1'b1;
        reset        = 1'b1;
        en           = 1'b0;
        pattern      = PAT_BARS;
        gain_red     = 8'd128;
        gain_green   = 8'd128;
        gain_blue    = 8'd128;
        offset_red   = 8'd0;
        offset_green = 8'd0;
        offset_blue  = 8'd0;
        repeat (10) begin
            @(negedge disp_clk);
            check_quiet();
        end
        @(posedge disp_clk);
        reset <= 1'b0;
        for (int r = 0; r < NUM_ROWS && run_ok; r++) begin
            run_row(ROWS[r], run_ok);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
